// File: design/bpm_regs_pkg.sv
package bpm_regs_pkg;

	parameter int data_w = 16;
	parameter int word_w = 32;

	//////////////////////////////////////////////////
	// Register map, word offsets from the bus base
	//////////////////////////////////////////////////
	typedef enum logic [6:0] {
		reg_status   = 7'h00,
		reg_control  = 7'h01,
		reg_version  = 7'h02,
		reg_x        = 7'h08,
		reg_y        = 7'h09,
		reg_s        = 7'h0A,
		reg_trig_dl  = 7'h16,
		reg_bpm_dia  = 7'h17,
		reg_trig_th  = 7'h18,
		reg_trig_dt  = 7'h19,
		reg_evt_len  = 7'h1A,
		reg_afe_ctrl = 7'h58,
		reg_cha_gain = 7'h60,
		reg_chb_gain = 7'h61,
		reg_chc_gain = 7'h62,
		reg_chd_gain = 7'h63,
		reg_none     = 7'h7F // Nothing mapped here
	} reg_sel_e;

	// Processor side of the BRAM-style port
	typedef struct packed {
		logic              en;
		logic [3:0]        we;
		logic [word_w-1:0] addr;
		logic [word_w-1:0] wr_data;
	} bus_req_t;

	// Decoded bus cycle
	typedef struct packed {
		logic              wr;
		logic              rd;
		reg_sel_e          sel;
		logic [word_w-1:0] data;
	} reg_cmd_t;

	// Settings for the signal processor
	typedef struct packed {
		logic [data_w-1:0] bpm_dia;
		logic [data_w-1:0] trig_th;
		logic [data_w-1:0] trig_dt;
		logic [data_w-1:0] trig_dl;
		logic [data_w-1:0] evt_len;
		logic [word_w-1:0] cha_gain;
		logic [word_w-1:0] chb_gain;
		logic [word_w-1:0] chc_gain;
		logic [word_w-1:0] chd_gain;
	} proc_cfg_t;

	// Results coming back from the signal processor
	typedef struct packed {
		logic [data_w-1:0] status;
		logic [data_w-1:0] x;
		logic [data_w-1:0] y;
		logic [data_w-1:0] s;
	} meas_t;

endpackage

// File: design/bpm_afe_pkg.sv
package bpm_afe_pkg;

	parameter int att_bits = 6; // DAT-31 step attenuator word

	// Control register bit view
	typedef struct packed {
		logic       soft_rst;     // 15
		logic       spare_14;
		logic       force_pickup; // 13
		logic [5:0] spare_12_7;
		logic       auto_gain;    // 6
		logic [1:0] spare_5_4;
		logic       sma_en;       // 3
		logic [2:0] spare_2_0;
	} ctrl_reg_t;

	// AFE control register bit view
	typedef struct packed {
		logic [1:0]          spare_15_14;
		logic [att_bits-1:0] att_set;  // 13..8
		logic [2:0]          spare_7_5;
		logic [4:0]          man_gain; // 4..0
	} afe_reg_t;

	// Attenuator serial loader
	typedef enum logic [1:0] {
		att_idle,
		att_low,
		att_high,
		att_latch
	} att_state_e;

endpackage

// File: design/bus_decode.sv
`timescale 1ns/1ns

module bus_decode #(
	parameter logic [bpm_regs_pkg::word_w-1:0] base_addr = 32'h41710000
) (
	input  bpm_regs_pkg::bus_req_t bus,
	output bpm_regs_pkg::reg_cmd_t cmd
);

	logic [bpm_regs_pkg::word_w-1:0] offset;
	logic [6:0]                      word;
	logic                            in_range;
	logic                            full_we;
	logic                            no_we;
	bpm_regs_pkg::reg_sel_e          sel;

	// Byte offset from the block base
	assign offset   = bus.addr - base_addr;
	assign word     = offset[8:2];
	assign in_range = (offset[bpm_regs_pkg::word_w-1:9] == '0) && (offset[1:0] == 2'b00);

	// Only whole-word writes count, partial enables are dropped
	assign full_we = (bus.we == 4'hF);
	assign no_we   = (bus.we == 4'h0);

	always_comb begin
		sel = bpm_regs_pkg::reg_none;
		if (in_range) begin
			case (word)
				bpm_regs_pkg::reg_status,   bpm_regs_pkg::reg_control,
				bpm_regs_pkg::reg_version,  bpm_regs_pkg::reg_x,
				bpm_regs_pkg::reg_y,        bpm_regs_pkg::reg_s,
				bpm_regs_pkg::reg_trig_dl,  bpm_regs_pkg::reg_bpm_dia,
				bpm_regs_pkg::reg_trig_th,  bpm_regs_pkg::reg_trig_dt,
				bpm_regs_pkg::reg_evt_len,  bpm_regs_pkg::reg_afe_ctrl,
				bpm_regs_pkg::reg_cha_gain, bpm_regs_pkg::reg_chb_gain,
				bpm_regs_pkg::reg_chc_gain, bpm_regs_pkg::reg_chd_gain:
					sel = bpm_regs_pkg::reg_sel_e'(word);
				default:
					sel = bpm_regs_pkg::reg_none;
			endcase
		end
	end

	assign cmd.wr   = bus.en && full_we && (sel != bpm_regs_pkg::reg_none);
	assign cmd.rd   = bus.en && no_we;  // Unmapped reads still go through, they return zero
	assign cmd.sel  = (bus.en && (full_we || no_we)) ? sel : bpm_regs_pkg::reg_none;
	assign cmd.data = bus.wr_data;

endmodule

// File: design/reg_execute.sv
`timescale 1ns/1ns

module reg_execute (
	input  logic                    clk,
	input  logic                    rst,
	input  bpm_regs_pkg::reg_cmd_t  cmd,
	output bpm_afe_pkg::ctrl_reg_t  ctrl,
	output bpm_afe_pkg::afe_reg_t   afe,
	output bpm_regs_pkg::proc_cfg_t cfg,
	output logic                    proc_rst
);

	logic [bpm_regs_pkg::data_w-1:0] wr_half;

	assign wr_half = cmd.data[bpm_regs_pkg::data_w-1:0]; // 16 bit registers keep the low half

	//////////////////////////////////////////////////
	// Writable registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl <= '0;
			afe  <= '0;
			cfg  <= '0;
		end else if (cmd.wr) begin
			case (cmd.sel)
				bpm_regs_pkg::reg_control:  ctrl <= wr_half;
				bpm_regs_pkg::reg_afe_ctrl: afe  <= wr_half;
				bpm_regs_pkg::reg_bpm_dia:  cfg.bpm_dia <= wr_half;
				bpm_regs_pkg::reg_trig_th:  cfg.trig_th <= wr_half;
				bpm_regs_pkg::reg_trig_dt:  cfg.trig_dt <= wr_half;
				bpm_regs_pkg::reg_trig_dl:  cfg.trig_dl <= wr_half;
				bpm_regs_pkg::reg_evt_len:  cfg.evt_len <= wr_half;
				bpm_regs_pkg::reg_cha_gain: cfg.cha_gain <= cmd.data;
				bpm_regs_pkg::reg_chb_gain: cfg.chb_gain <= cmd.data;
				bpm_regs_pkg::reg_chc_gain: cfg.chc_gain <= cmd.data;
				bpm_regs_pkg::reg_chd_gain: cfg.chd_gain <= cmd.data;
				default: begin
					// Status, version and results are read only
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Processor soft reset
	//////////////////////////////////////////////////

	// Held while the control bit stays set, one cycle behind it
	always_ff @(posedge clk) begin
		proc_rst <= rst || ctrl.soft_rst;
	end

endmodule

// File: design/read_result.sv
`timescale 1ns/1ns

module read_result #(
	parameter logic [bpm_regs_pkg::word_w-1:0] fpga_version = 32'd20170508
) (
	input  logic                              clk,
	input  logic                              rst,
	input  bpm_regs_pkg::reg_cmd_t            cmd,
	input  bpm_afe_pkg::ctrl_reg_t            ctrl,
	input  bpm_afe_pkg::afe_reg_t             afe,
	input  bpm_regs_pkg::proc_cfg_t           cfg,
	input  bpm_regs_pkg::meas_t               meas,
	output logic [bpm_regs_pkg::word_w-1:0]   rd_data
);

	localparam int ext_w = bpm_regs_pkg::word_w - bpm_regs_pkg::data_w;

	function automatic logic [bpm_regs_pkg::word_w-1:0] sext(
		input logic [bpm_regs_pkg::data_w-1:0] v
	);
		return {{ext_w{v[bpm_regs_pkg::data_w-1]}}, v};
	endfunction

	function automatic logic [bpm_regs_pkg::word_w-1:0] zext(
		input logic [bpm_regs_pkg::data_w-1:0] v
	);
		return {{ext_w{1'b0}}, v};
	endfunction

	// Read word is loaded on the read cycle and held until the next one
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_data <= '0;
		end else if (cmd.rd) begin
			case (cmd.sel)
				bpm_regs_pkg::reg_status:   rd_data <= sext(meas.status);
				bpm_regs_pkg::reg_control:  rd_data <= sext(ctrl);
				bpm_regs_pkg::reg_afe_ctrl: rd_data <= sext(afe);
				bpm_regs_pkg::reg_version:  rd_data <= fpga_version;
				bpm_regs_pkg::reg_x:        rd_data <= zext(meas.x);
				bpm_regs_pkg::reg_y:        rd_data <= zext(meas.y);
				bpm_regs_pkg::reg_s:        rd_data <= zext(meas.s);
				bpm_regs_pkg::reg_bpm_dia:  rd_data <= zext(cfg.bpm_dia);
				bpm_regs_pkg::reg_trig_th:  rd_data <= zext(cfg.trig_th);
				bpm_regs_pkg::reg_trig_dt:  rd_data <= zext(cfg.trig_dt);
				bpm_regs_pkg::reg_trig_dl:  rd_data <= zext(cfg.trig_dl);
				bpm_regs_pkg::reg_evt_len:  rd_data <= zext(cfg.evt_len);
				bpm_regs_pkg::reg_cha_gain: rd_data <= cfg.cha_gain;
				bpm_regs_pkg::reg_chb_gain: rd_data <= cfg.chb_gain;
				bpm_regs_pkg::reg_chc_gain: rd_data <= cfg.chc_gain;
				bpm_regs_pkg::reg_chd_gain: rd_data <= cfg.chd_gain;
				default:                    rd_data <= '0; // Unmapped
			endcase
		end
	end

endmodule

// File: design/afe_control.sv
`timescale 1ns/1ns

module afe_control (
	input  logic                   clk,
	input  logic                   rst,
	input  bpm_afe_pkg::ctrl_reg_t ctrl,
	input  bpm_afe_pkg::afe_reg_t  afe,
	input  logic                   trig_in,
	input  logic                   cal_on,
	input  logic [4:0]             auto_gain,
	output logic                   sma_out,
	output logic                   afe_pickup,
	output logic                   afe_cal,
	output logic [4:0]             vga_gain,
	output logic                   att_data,
	output logic                   att_clk,
	output logic                   att_le
);

	localparam int cnt_w = $clog2(bpm_afe_pkg::att_bits);
	localparam logic [cnt_w-1:0] last_bit = cnt_w'(bpm_afe_pkg::att_bits - 1);

	bpm_afe_pkg::att_state_e             state;
	logic [cnt_w-1:0]                    bit_cnt;
	logic [bpm_afe_pkg::att_bits-1:0]    shift_reg;
	logic [bpm_afe_pkg::att_bits-1:0]    last_set; // Setting of the most recent load
	logic                                first_load;
	logic                                pending;

	//////////////////////////////////////////////////
	// Front-end pins
	//////////////////////////////////////////////////

	// SMA path goes through a NAND gate on the board
	assign sma_out    = ctrl.sma_en ? ~trig_in : 1'b1;
	assign afe_pickup = ctrl.force_pickup ? 1'b1 : cal_on;
	assign afe_cal    = ~afe_pickup;
	assign vga_gain   = ctrl.auto_gain ? auto_gain : afe.man_gain;

	//////////////////////////////////////////////////
	// Attenuator serial loader
	//////////////////////////////////////////////////
	assign pending = first_load || (afe.att_set != last_set);

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= bpm_afe_pkg::att_idle;
			bit_cnt    <= '0;
			last_set   <= '0;
			first_load <= 1'b1;
		end else begin
			case (state)
				bpm_afe_pkg::att_idle: begin
					if (pending) begin
						shift_reg  <= afe.att_set; // Snapshot, later changes wait for the next load
						last_set   <= afe.att_set;
						first_load <= 1'b0;
						bit_cnt    <= '0;
						state      <= bpm_afe_pkg::att_low;
					end
				end
				bpm_afe_pkg::att_low: state <= bpm_afe_pkg::att_high;
				bpm_afe_pkg::att_high: begin
					if (bit_cnt == last_bit) begin
						state <= bpm_afe_pkg::att_latch;
					end else begin
						shift_reg <= {shift_reg[bpm_afe_pkg::att_bits-2:0], 1'b0};
						bit_cnt   <= bit_cnt + 1'b1;
						state     <= bpm_afe_pkg::att_low;
					end
				end
				default: state <= bpm_afe_pkg::att_idle; // Latch lasts one cycle
			endcase
		end
	end

	// MSB first, stable through both halves of the bit
	assign att_data = ((state == bpm_afe_pkg::att_low) || (state == bpm_afe_pkg::att_high))
		? shift_reg[bpm_afe_pkg::att_bits-1] : 1'b0;
	assign att_clk  = (state == bpm_afe_pkg::att_high);
	assign att_le   = (state == bpm_afe_pkg::att_latch);

endmodule

// File: design/bpm_ctrl_top.sv
`timescale 1ns/1ns

module bpm_ctrl_top #(
	parameter logic [bpm_regs_pkg::word_w-1:0] base_addr    = 32'h41710000,
	parameter logic [bpm_regs_pkg::word_w-1:0] fpga_version = 32'd20170508
) (
	input  logic                            clk,
	input  logic                            rst,
	input  bpm_regs_pkg::bus_req_t          bus,
	output logic [bpm_regs_pkg::word_w-1:0] rd_data,
	input  bpm_regs_pkg::meas_t             meas,
	input  logic                            trig_in,
	input  logic                            cal_on,
	input  logic [4:0]                      auto_gain,
	output bpm_regs_pkg::proc_cfg_t         cfg,
	output logic                            proc_rst,
	output logic                            sma_out,
	output logic                            afe_pickup,
	output logic                            afe_cal,
	output logic [4:0]                      vga_gain,
	output logic                            att_data,
	output logic                            att_clk,
	output logic                            att_le
);

	bpm_regs_pkg::reg_cmd_t cmd;
	bpm_afe_pkg::ctrl_reg_t ctrl;
	bpm_afe_pkg::afe_reg_t  afe;

	//////////////////////////////////////////////////
	// Decode, execute and read back
	//////////////////////////////////////////////////
	bus_decode #(.base_addr(base_addr)) u_decode (.bus(bus), .cmd(cmd));

	reg_execute u_exec (
		.clk(clk), .rst(rst), .cmd(cmd),
		.ctrl(ctrl), .afe(afe), .cfg(cfg), .proc_rst(proc_rst)
	);

	read_result #(.fpga_version(fpga_version)) u_read (
		.clk(clk), .rst(rst), .cmd(cmd), .ctrl(ctrl), .afe(afe),
		.cfg(cfg), .meas(meas), .rd_data(rd_data)
	);

	// Front end pins and attenuator
	afe_control u_afe (
		.clk(clk), .rst(rst), .ctrl(ctrl), .afe(afe),
		.trig_in(trig_in), .cal_on(cal_on), .auto_gain(auto_gain),
		.sma_out(sma_out), .afe_pickup(afe_pickup), .afe_cal(afe_cal),
		.vga_gain(vga_gain), .att_data(att_data), .att_clk(att_clk), .att_le(att_le)
	);

endmodule

// File: bench/bpm_ctrl_assertions.sv
`timescale 1ns/1ns

module bpm_ctrl_assertions (
	input logic                   clk,
	input logic                   rst,
	input bpm_regs_pkg::bus_req_t bus,
	input logic [31:0]            rd_data,
	input bpm_afe_pkg::ctrl_reg_t ctrl,
	input logic                   proc_rst,
	input logic                   att_le,
	input logic                   att_clk,
	input logic                   afe_cal,
	input logic                   afe_pickup
);

	int n_fail = 0; // Summed into the testbench result

	//////////////////////////////////////////////////
	// Attenuator strobe and front-end pins
	//////////////////////////////////////////////////
	le_width: assert property (@(posedge clk) disable iff (rst) att_le |=> !att_le)
		else begin
			$error("att_le stayed high for more than one cycle");
			n_fail++;
		end

	// Latch comes with the clock low, straight after the last clock pulse
	le_clk_low: assert property (@(posedge clk) disable iff (rst)
		att_le |-> (!att_clk && $past(att_clk)))
		else begin
			$error("att_le came while att_clk was high or not after a clock pulse");
			n_fail++;
		end

	cal_inverse: assert property (@(posedge clk) disable iff (rst) afe_cal != afe_pickup)
		else begin
			$error("afe_cal is not the inverse of afe_pickup");
			n_fail++;
		end

	//////////////////////////////////////////////////
	// Read data and soft reset
	//////////////////////////////////////////////////
	rd_hold: assert property (@(posedge clk) disable iff (rst)
		!$stable(rd_data) |-> $past(bus.en && (bus.we == 4'h0)))
		else begin
			$error("rd_data changed without a read in the previous cycle");
			n_fail++;
		end

	// proc_rst trails rst or the control bit by one cycle
	soft_rst_delay: assert property (@(posedge clk)
		1'b1 |=> (proc_rst == $past(rst || ctrl.soft_rst)))
		else begin
			$error("proc_rst does not follow the soft reset one cycle later");
			n_fail++;
		end

endmodule

bind bpm_ctrl_top bpm_ctrl_assertions checks (.*);

// File: bench/tb_bpm_ctrl.sv
`timescale 1ns/1ns

module tb_bpm_ctrl;

	localparam logic [31:0] base    = 32'h41710000;
	localparam logic [31:0] version = 32'd20170508;

	logic                    clk;
	logic                    rst;
	bpm_regs_pkg::bus_req_t  bus;
	logic [31:0]             rd_data;
	bpm_regs_pkg::meas_t     meas;
	logic                    trig_in, cal_on;
	logic [4:0]              auto_gain, vga_gain;
	bpm_regs_pkg::proc_cfg_t cfg;
	logic                    proc_rst, sma_out, afe_pickup, afe_cal;
	logic                    att_data, att_clk, att_le;

	int          errors = 0;
	int          tests = 0;
	int          att_errors = 0;
	int          nbits = 0;
	int          n0;
	logic        prev_clk = 1'b0;
	logic [31:0] r;
	logic [31:0] wval [11];
	logic [31:0] ro_exp [5];
	logic [6:0]  wr_off [11] = '{7'h01, 7'h58, 7'h17, 7'h18, 7'h19, 7'h16, 7'h1A,
		7'h60, 7'h61, 7'h62, 7'h63};
	logic [6:0]  ro_off [5] = '{7'h00, 7'h02, 7'h08, 7'h09, 7'h0A};
	logic [5:0]  att_a, att_b, shift_in;
	logic [5:0]  loads [$]; // One word per att_le
	logic [15:0] ctrl_val;
	logic [7:0]  pins_exp;

	bpm_ctrl_top #(.base_addr(base), .fpga_version(version)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] reg_addr(input logic [6:0] off);
		return base + {23'b0, off, 2'b00};
	endfunction

	// Captured on the rising edge between the two falling edges
	task automatic bus_cycle(input logic [3:0] we, input logic [31:0] addr,
		input logic [31:0] data);
		@(negedge clk);
		bus = {1'b1, we, addr, data};
		@(negedge clk);
		bus.en = 1'b0;
	endtask

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got == exp) else begin
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic read_check(input logic [6:0] off, input logic [31:0] exp);
		bus_cycle(4'h0, reg_addr(off), '0);
		expect_eq(rd_data, exp, $sformatf("read of offset %h", off));
	endtask

	task automatic test_done(input string name);
		tests++;
		$display("Test %0d (%s) finished, %0d errors so far", tests, name, errors);
	endtask

	// Attenuator bit at each att_clk rise
	always @(negedge clk) begin
		if (!rst && att_clk && !prev_clk) begin
			shift_in = {shift_in[4:0], att_data};
			nbits++;
		end
		if (!rst && att_le) begin
			if (nbits != 6) begin
				$display("Attenuator load ended after %0d clock pulses instead of 6", nbits);
				att_errors++;
			end
			loads.push_back(shift_in);
			nbits = 0;
		end
		prev_clk = att_clk;
	end

	initial begin
		r = $urandom(32'h923b682e);
		rst = 1'b1;
		bus = '0;
		meas = '0;
		trig_in = 1'b0;
		cal_on = 1'b0;
		auto_gain = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		//////////////////////////////////////////////////
		// Register map
		//////////////////////////////////////////////////
		for (int i = 0; i < 11; i++) begin
			wval[i] = $urandom;
			if (i == 0) wval[i][15] = 1'b1; // Control read must sign-extend
			bus_cycle(4'hF, reg_addr(wr_off[i]), wval[i]);
		end
		for (int i = 0; i < 11; i++) begin
			if (i < 2)
				r = {{16{wval[i][15]}}, wval[i][15:0]};
			else if (i < 7)
				r = {16'h0, wval[i][15:0]};
			else
				r = wval[i];
			read_check(wr_off[i], r);
		end
		assert (cfg == {wval[2][15:0], wval[3][15:0], wval[4][15:0], wval[5][15:0],
			wval[6][15:0], wval[7], wval[8], wval[9], wval[10]}) else begin
			$display("Fail %0t: cfg does not match the written registers", $time);
			errors++;
		end
		test_done("writable registers");

		r = $urandom;
		meas.status = {1'b1, r[14:0]}; // Negative status
		meas.x = r[31:16];
		r = $urandom;
		meas.y = r[15:0];
		meas.s = r[31:16];
		ro_exp[0] = {16'hFFFF, meas.status};
		ro_exp[1] = version;
		ro_exp[2] = {16'h0, meas.x};
		ro_exp[3] = {16'h0, meas.y};
		ro_exp[4] = {16'h0, meas.s};
		for (int pass = 0; pass < 2; pass++) begin
			for (int i = 0; i < 5; i++) begin
				if (pass == 1) bus_cycle(4'hF, reg_addr(ro_off[i]), $urandom);
				read_check(ro_off[i], ro_exp[i]);
			end
		end
		test_done("read-only registers");

		read_check(7'h02, version);
		read_check(7'h03, 32'h0);
		read_check(7'h02, version);
		bus_cycle(4'h0, base + 32'h1000, '0);
		expect_eq(rd_data, 32'h0, "read past the register block");
		bus_cycle(4'h3, reg_addr(7'h17), ~wval[2]);
		bus_cycle(4'hE, reg_addr(7'h17), ~wval[2]);
		read_check(7'h17, {16'h0, wval[2][15:0]});
		test_done("unmapped and partial");

		//////////////////////////////////////////////////
		// Front end
		//////////////////////////////////////////////////
		for (int i = 0; i < 8; i++) begin
			r = $urandom;
			ctrl_val = {1'b0, r[14:0]};
			ctrl_val[3] = i[0];  // Every mix of the three pin controls
			ctrl_val[13] = i[1];
			ctrl_val[6] = i[2];
			bus_cycle(4'hF, reg_addr(7'h01), {16'h0, ctrl_val});
			trig_in = r[16];
			cal_on = r[17];
			auto_gain = r[22:18];
			#10;
			pins_exp[7] = ctrl_val[3] ? ~trig_in : 1'b1;
			pins_exp[6] = ctrl_val[13] ? 1'b1 : cal_on;
			pins_exp[5] = ~pins_exp[6];
			pins_exp[4:0] = ctrl_val[6] ? auto_gain : wval[1][4:0];
			expect_eq({24'b0, sma_out, afe_pickup, afe_cal, vga_gain}, {24'b0, pins_exp},
				"pins");
		end
		test_done("front-end pins");

		r = $urandom;
		att_a = (r[5:0] == wval[1][13:8]) ? ~r[5:0] : r[5:0];
		att_b = ~att_a;
		n0 = loads.size();
		bus_cycle(4'hF, reg_addr(7'h58), {18'h0, att_a, 8'h0});
		bus_cycle(4'hF, reg_addr(7'h58), {18'h0, att_b, 8'h0}); // Lands mid-load
		for (int t = 0; t < 100 && loads.size() < n0 + 2; t++)
			@(negedge clk);
		if (loads.size() < n0 + 2) begin
			$display("Timed out waiting for two attenuator loads");
			errors++;
		end else begin
			expect_eq({26'b0, loads[n0]}, {26'b0, att_a}, "first attenuator load");
			expect_eq({26'b0, loads[n0 + 1]}, {26'b0, att_b}, "second attenuator load");
		end
		test_done("attenuator loader");

		expect_eq({31'b0, proc_rst}, 32'h0, "proc_rst before the soft reset");
		bus_cycle(4'hF, reg_addr(7'h01), 32'h8000);
		expect_eq({31'b0, proc_rst}, 32'h0, "proc_rst as the write lands");
		@(negedge clk);
		expect_eq({31'b0, proc_rst}, 32'h1, "proc_rst one cycle later");
		bus_cycle(4'hF, reg_addr(7'h01), 32'h0);
		@(negedge clk);
		expect_eq({31'b0, proc_rst}, 32'h0, "proc_rst after clearing");
		test_done("soft reset");

		errors += att_errors + UUT.checks.n_fail;
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: filelist.f
design/bpm_regs_pkg.sv
design/bpm_afe_pkg.sv
design/bus_decode.sv
design/reg_execute.sv
design/read_result.sv
design/afe_control.sv
design/bpm_ctrl_top.sv
bench/bpm_ctrl_assertions.sv
bench/tb_bpm_ctrl.sv

// File: Makefile
TOP = tb_bpm_ctrl

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) --Mdir build -f filelist.f
	@out="$$(./build/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

clean:
	rm -rf build
